/* rtl/dbg_cfg_pkg.sv */
package dbg_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Protocol bytes
  //////////////////////////////////////////////////////////////////////

  // Challenge byte, echoed back as the acknowledge
  localparam logic [7:0] CMD_ACK   = 8'h06;
  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;
  localparam logic [7:0] REPLY_EOT = 8'h04;

  // Address and length fields, little endian
  localparam int unsigned FIELD_BYTES = 8;

  //////////////////////////////////////////////////////////////////////
  // Default sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DEF_CLKS_PER_BIT = 16;
  localparam int unsigned DEF_MEM_BYTES    = 256;
  // Also the number of credits held by the engine
  localparam int unsigned DEF_TX_DEPTH     = 4;

endpackage

/* rtl/dbg_types_pkg.sv */
package dbg_types_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] len_t;

  // Receive channel, valid for one cycle per byte
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_byte_t;

  // Reply channel into the tx FIFO, guarded by credits
  typedef struct packed {
    logic  valid;
    byte_t data;
  } tx_push_t;

  // Command engine states
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    LEN,
    ACK,
    WDATA,
    RDATA,
    EOT
  } cmd_state_e;

endpackage

/* rtl/uart_rx_deser.sv */
module uart_rx_deser #(
  parameter int unsigned ClksPerBit = dbg_cfg_pkg::DEF_CLKS_PER_BIT
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_i,
  output dbg_types_pkg::rx_byte_t rx_byte_o
);

  localparam int unsigned CntW = (ClksPerBit > 2) ? $clog2(ClksPerBit) : 1;
  localparam logic [CntW-1:0] HalfBit = CntW'(ClksPerBit / 2 - 1);
  localparam logic [CntW-1:0] FullBit = CntW'(ClksPerBit - 1);

  logic [1:0]           sync_q;
  logic                 line_prev_q;
  logic                 busy_q;
  logic [CntW-1:0]      cnt_q;
  logic [3:0]           bit_q;
  logic                 valid_q;
  dbg_types_pkg::byte_t shift_q;
  logic                 line;
  logic                 start;
  logic                 sample;

  assign line   = sync_q[1];
  assign start  = !busy_q && line_prev_q && !line;
  // Mid-bit point of the current bit
  assign sample = busy_q && (cnt_q == '0);

  // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q      <= 2'b11;
      line_prev_q <= 1'b1;
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      bit_q       <= '0;
      valid_q     <= 1'b0;
    end else begin
      sync_q      <= {sync_q[0], rx_i};
      line_prev_q <= line;
      valid_q     <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= HalfBit;
        bit_q  <= '0;
      end else if (sample) begin
        cnt_q <= FullBit;
        bit_q <= bit_q + 4'd1;
        if (bit_q == 4'd0 && line) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= line;
        end
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (sample && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid = valid_q;
  assign rx_byte_o.data  = shift_q;

  // Frames are at least ten bit times apart
  assert property (@(posedge clk) disable iff (!rst_n_i)
    rx_byte_o.valid |=> !rx_byte_o.valid);

endmodule

/* rtl/dbg_cmd_engine.sv */
module dbg_cmd_engine #(
  parameter int unsigned MemBytes = dbg_cfg_pkg::DEF_MEM_BYTES,
  parameter int unsigned TxDepth  = dbg_cfg_pkg::DEF_TX_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  dbg_types_pkg::rx_byte_t rx_byte_i,
  output dbg_types_pkg::tx_push_t tx_push_o,
  input  logic                    credit_return_i
);

  localparam int unsigned AddrW  = (MemBytes > 1) ? $clog2(MemBytes) : 1;
  localparam int unsigned CredW  = $clog2(TxDepth + 1);
  localparam int unsigned FieldW = 8 * dbg_cfg_pkg::FIELD_BYTES;
  localparam int unsigned FcntW  = $clog2(dbg_cfg_pkg::FIELD_BYTES);
  localparam int unsigned LenW   = $bits(dbg_types_pkg::len_t);

  dbg_types_pkg::cmd_state_e state_q;
  dbg_types_pkg::byte_t      mem_q [MemBytes];
  logic [FieldW-9:0]         field_q;
  logic [FieldW-1:0]         field_nxt;
  logic [FcntW-1:0]          fcnt_q;
  logic                      field_last;
  logic [AddrW-1:0]          ptr_q;
  dbg_types_pkg::len_t       len_q;
  logic                      rd_q;
  logic                      chal_q;
  logic [CredW-1:0]          credits_q;
  logic                      has_credit;
  logic                      mem_we;

  //////////////////////////////////////////////////////////////////////
  // Field gathering
  //////////////////////////////////////////////////////////////////////

  // New byte enters at the top, so the first byte ends up lowest
  assign field_nxt  = {rx_byte_i.data, field_q};
  assign field_last = (fcnt_q == FcntW'(dbg_cfg_pkg::FIELD_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rx_byte_i.valid &&
        (state_q == dbg_types_pkg::ADDR || state_q == dbg_types_pkg::LEN)) begin
      field_q <= field_nxt[FieldW-1:8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= dbg_types_pkg::IDLE;
      fcnt_q  <= '0;
      ptr_q   <= '0;
      len_q   <= '0;
      rd_q    <= 1'b0;
      chal_q  <= 1'b0;
    end else begin
      case (state_q)
        dbg_types_pkg::IDLE: begin
          if (rx_byte_i.valid) begin
            rd_q   <= (rx_byte_i.data == dbg_cfg_pkg::CMD_READ);
            chal_q <= (rx_byte_i.data == dbg_cfg_pkg::CMD_ACK);
            fcnt_q <= '0;
            if (rx_byte_i.data == dbg_cfg_pkg::CMD_ACK) begin
              state_q <= dbg_types_pkg::ACK;
            end else if (rx_byte_i.data == dbg_cfg_pkg::CMD_READ ||
                         rx_byte_i.data == dbg_cfg_pkg::CMD_WRITE) begin
              state_q <= dbg_types_pkg::ADDR;
            end
          end
        end
        dbg_types_pkg::ADDR: begin
          if (rx_byte_i.valid) begin
            fcnt_q <= field_last ? '0 : fcnt_q + 1'b1;
            if (field_last) begin
              // Upper address bits fall away, so addresses wrap
              ptr_q   <= field_nxt[AddrW-1:0];
              state_q <= dbg_types_pkg::LEN;
            end
          end
        end
        dbg_types_pkg::LEN: begin
          if (rx_byte_i.valid) begin
            fcnt_q <= field_last ? '0 : fcnt_q + 1'b1;
            if (field_last) begin
              len_q   <= field_nxt[LenW-1:0];
              state_q <= dbg_types_pkg::ACK;
            end
          end
        end
        dbg_types_pkg::ACK: begin
          if (has_credit) begin
            if (chal_q) begin
              state_q <= dbg_types_pkg::IDLE;
            end else if (len_q == '0) begin
              state_q <= dbg_types_pkg::EOT;
            end else if (rd_q) begin
              state_q <= dbg_types_pkg::RDATA;
            end else begin
              state_q <= dbg_types_pkg::WDATA;
            end
          end
        end
        dbg_types_pkg::RDATA: begin
          if (has_credit) begin
            ptr_q <= ptr_q + 1'b1;
            len_q <= len_q - 1'b1;
            if (len_q == LenW'(1)) begin
              state_q <= dbg_types_pkg::EOT;
            end
          end
        end
        dbg_types_pkg::WDATA: begin
          if (rx_byte_i.valid) begin
            ptr_q <= ptr_q + 1'b1;
            len_q <= len_q - 1'b1;
            if (len_q == LenW'(1)) begin
              state_q <= dbg_types_pkg::EOT;
            end
          end
        end
        dbg_types_pkg::EOT: begin
          if (has_credit) begin
            state_q <= dbg_types_pkg::IDLE;
          end
        end
        default: state_q <= dbg_types_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory and reply
  //////////////////////////////////////////////////////////////////////

  assign mem_we = (state_q == dbg_types_pkg::WDATA) && rx_byte_i.valid;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem_q[ptr_q] <= rx_byte_i.data;
    end
  end

  assign has_credit = (credits_q != '0);

  always_comb begin
    tx_push_o.valid = 1'b0;
    tx_push_o.data  = mem_q[ptr_q];
    case (state_q)
      dbg_types_pkg::ACK: begin
        tx_push_o.valid = has_credit;
        tx_push_o.data  = dbg_cfg_pkg::CMD_ACK;
      end
      dbg_types_pkg::RDATA: begin
        tx_push_o.valid = has_credit;
      end
      dbg_types_pkg::EOT: begin
        tx_push_o.valid = has_credit;
        tx_push_o.data  = dbg_cfg_pkg::REPLY_EOT;
      end
      default: tx_push_o.valid = 1'b0;
    endcase
  end

  // One credit per free FIFO slot in the serializer
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= CredW'(TxDepth);
    end else begin
      credits_q <= credits_q + CredW'(credit_return_i) - CredW'(tx_push_o.valid);
    end
  end

  // Serializer never hands back more credits than were taken
  assert property (@(posedge clk) disable iff (!rst_n_i)
    credits_q <= CredW'(TxDepth));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_push_o.valid |-> has_credit);

endmodule

/* rtl/uart_tx_ser.sv */
module uart_tx_ser #(
  parameter int unsigned ClksPerBit = dbg_cfg_pkg::DEF_CLKS_PER_BIT,
  parameter int unsigned TxDepth    = dbg_cfg_pkg::DEF_TX_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  dbg_types_pkg::tx_push_t tx_push_i,
  output logic                    credit_return_o,
  output logic                    tx_o
);

  localparam int unsigned PtrW  = (TxDepth > 1) ? $clog2(TxDepth) : 1;
  localparam int unsigned CntW  = $clog2(TxDepth + 1);
  localparam int unsigned BaudW = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;
  localparam logic [PtrW-1:0]  LastPtr = PtrW'(TxDepth - 1);
  localparam logic [BaudW-1:0] FullBit = BaudW'(ClksPerBit - 1);

  dbg_types_pkg::byte_t fifo_q [TxDepth];
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [CntW-1:0]      count_q;
  logic                 busy_q;
  logic [9:0]           frame_q;
  logic [BaudW-1:0]     baud_q;
  logic [3:0]           bit_q;
  logic                 credit_q;
  logic                 bit_end;
  logic                 frame_end;
  logic                 load;

  assign bit_end   = busy_q && (baud_q == '0);
  assign frame_end = bit_end && (bit_q == 4'd9);
  // Next frame may start in the last cycle of the current stop bit
  assign load      = (!busy_q || frame_end) && (count_q != '0);

  always_ff @(posedge clk) begin
    if (tx_push_i.valid) begin
      fifo_q[wr_ptr_q] <= tx_push_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      frame_q  <= '1;
      baud_q   <= '0;
      bit_q    <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= load;
      count_q  <= count_q + CntW'(tx_push_i.valid) - CntW'(load);
      if (tx_push_i.valid) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (load) begin
        // Stop, data LSB first, start
        frame_q  <= {1'b1, fifo_q[rd_ptr_q], 1'b0};
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
        busy_q   <= 1'b1;
        baud_q   <= FullBit;
        bit_q    <= '0;
      end else if (frame_end) begin
        busy_q  <= 1'b0;
        frame_q <= '1;
      end else if (bit_end) begin
        frame_q <= {1'b1, frame_q[9:1]};
        baud_q  <= FullBit;
        bit_q   <= bit_q + 4'd1;
      end else if (busy_q) begin
        baud_q <= baud_q - 1'b1;
      end
    end
  end

  assign tx_o            = frame_q[0];
  assign credit_return_o = credit_q;

  // Engine credits must keep the FIFO from overflowing
  assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_push_i.valid |-> (count_q < CntW'(TxDepth)));

endmodule

/* rtl/uart_dbg_bridge.sv */
module uart_dbg_bridge #(
  parameter int unsigned ClksPerBit = dbg_cfg_pkg::DEF_CLKS_PER_BIT,
  parameter int unsigned MemBytes   = dbg_cfg_pkg::DEF_MEM_BYTES,
  parameter int unsigned TxDepth    = dbg_cfg_pkg::DEF_TX_DEPTH
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  dbg_types_pkg::rx_byte_t rx_byte;
  dbg_types_pkg::tx_push_t tx_push;
  logic                    credit_return;

  // Line to byte
  uart_rx_deser #(
    .ClksPerBit ( ClksPerBit )
  ) u_rx (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .rx_i      ( uart_rx_i ),
    .rx_byte_o ( rx_byte   )
  );

  // Parser and target memory
  dbg_cmd_engine #(
    .MemBytes ( MemBytes ),
    .TxDepth  ( TxDepth  )
  ) u_engine (
    .clk             ( clk           ),
    .rst_n_i         ( rst_n_i       ),
    .rx_byte_i       ( rx_byte       ),
    .tx_push_o       ( tx_push       ),
    .credit_return_i ( credit_return )
  );

  // Reply FIFO and line driver
  uart_tx_ser #(
    .ClksPerBit ( ClksPerBit ),
    .TxDepth    ( TxDepth    )
  ) u_tx (
    .clk             ( clk           ),
    .rst_n_i         ( rst_n_i       ),
    .tx_push_i       ( tx_push       ),
    .credit_return_o ( credit_return ),
    .tx_o            ( uart_tx_o     )
  );

endmodule

/* tb/tb_uart_dbg_bridge.sv */
module tb_uart_dbg_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ClksPerBit = 8;
  localparam int unsigned MemBytes   = 256;
  localparam int unsigned TxDepth    = 4;

  logic clk;
  logic rst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  logic [15:0]          lfsr_q;
  dbg_types_pkg::byte_t model_q [MemBytes];
  dbg_types_pkg::byte_t cmd_q [$];
  dbg_types_pkg::byte_t exp_q [$];
  dbg_types_pkg::byte_t got_q [$];
  int unsigned          checks;
  int unsigned          errors;
  logic                 timed_out;

  uart_dbg_bridge #(
    .ClksPerBit ( ClksPerBit ),
    .MemBytes   ( MemBytes   ),
    .TxDepth    ( TxDepth    )
  ) u_dut (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and checking
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  function automatic logic [15:0] take_bits(input int unsigned n);
    logic [15:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("error %s got %h expected %h", name, got, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // UART host side
  //////////////////////////////////////////////////////////////////////

  // Start, 8 data bits LSB first, stop; called on a falling edge
  task automatic send_byte(input dbg_types_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i = frame[i];
      repeat (ClksPerBit) @(negedge clk);
    end
  endtask

  task automatic send_all();
    foreach (cmd_q[i]) begin
      send_byte(cmd_q[i]);
    end
  endtask

  task automatic recv_bytes(input int unsigned n, input int unsigned limit);
    dbg_types_pkg::byte_t b;
    int unsigned          waited;
    for (int unsigned k = 0; k < n; k++) begin
      waited = 0;
      while (uart_tx_o !== 1'b0 && waited < limit) begin
        @(negedge clk);
        waited++;
      end
      if (uart_tx_o !== 1'b0) begin
        errors++;
        timed_out = 1'b1;
        $display("reply byte %0d of %0d did not start in time", k, n);
        return;
      end
      // Half a bit to the middle of the start bit
      repeat (ClksPerBit / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (ClksPerBit) @(negedge clk);
        b[i] = uart_tx_o;
      end
      repeat (ClksPerBit) @(negedge clk);
      check_value("uart_tx_o stop bit", 16'(uart_tx_o), 16'h1);
      got_q.push_back(b);
    end
  endtask

  // Line must stay high, no start bit
  task automatic expect_quiet(input int unsigned bits, input string name);
    logic seen_low;
    seen_low = 1'b0;
    for (int unsigned i = 0; i < bits * ClksPerBit; i++) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        seen_low = 1'b1;
      end
    end
    check_value(name, 16'(seen_low), 16'h0);
  endtask

  // Send cmd_q while collecting the reply, then compare with exp_q
  task automatic run_cmd();
    int unsigned limit;
    int          n_cmp;
    if (!timed_out) begin
      limit = (cmd_q.size() + 4) * 10 * ClksPerBit;
      got_q.delete();
      fork
        send_all();
        recv_bytes(exp_q.size(), limit);
      join
      n_cmp = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (int i = 0; i < n_cmp; i++) begin
        check_value($sformatf("uart_tx_o byte %0d", i), 16'(got_q[i]), 16'(exp_q[i]));
      end
    end
    cmd_q.delete();
    exp_q.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Commands and model
  //////////////////////////////////////////////////////////////////////

  task automatic add_header(input dbg_types_pkg::byte_t cmd, input dbg_types_pkg::byte_t addr,
                            input dbg_types_pkg::len_t len);
    cmd_q.push_back(cmd);
    cmd_q.push_back(addr);
    // Upper field bytes are random, the bridge ignores them
    repeat (dbg_cfg_pkg::FIELD_BYTES - 1) cmd_q.push_back(8'(take_bits(8)));
    cmd_q.push_back(len[7:0]);
    cmd_q.push_back(len[15:8]);
    repeat (dbg_cfg_pkg::FIELD_BYTES - 2) cmd_q.push_back(8'(take_bits(8)));
  endtask

  task automatic do_write(input dbg_types_pkg::byte_t addr, input dbg_types_pkg::len_t len);
    dbg_types_pkg::byte_t d;
    add_header(dbg_cfg_pkg::CMD_WRITE, addr, len);
    for (int unsigned i = 0; i < len; i++) begin
      d = 8'(take_bits(8));
      cmd_q.push_back(d);
      model_q[(addr + i) % MemBytes] = d;
    end
    exp_q.push_back(dbg_cfg_pkg::CMD_ACK);
    exp_q.push_back(dbg_cfg_pkg::REPLY_EOT);
    run_cmd();
  endtask

  task automatic do_read(input dbg_types_pkg::byte_t addr, input dbg_types_pkg::len_t len);
    add_header(dbg_cfg_pkg::CMD_READ, addr, len);
    exp_q.push_back(dbg_cfg_pkg::CMD_ACK);
    for (int unsigned i = 0; i < len; i++) begin
      exp_q.push_back(model_q[(addr + i) % MemBytes]);
    end
    exp_q.push_back(dbg_cfg_pkg::REPLY_EOT);
    run_cmd();
  endtask

  function automatic dbg_types_pkg::len_t rand_len();
    return dbg_types_pkg::len_t'(take_bits(4) % 16'd12 + 16'd1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    dbg_types_pkg::byte_t unk;
    uart_rx_i = 1'b1;
    rst_n_i   = 1'b0;
    lfsr_q    = 16'd7633;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;

    expect_quiet(40, "uart_tx_o start after reset");

    // Challenge answered by a single ACK
    cmd_q.push_back(dbg_cfg_pkg::CMD_ACK);
    exp_q.push_back(dbg_cfg_pkg::CMD_ACK);
    run_cmd();
    expect_quiet(20, "uart_tx_o start after challenge");

    // Fill the whole memory so every read is predictable
    do_write(8'h00, 16'(MemBytes));

    repeat (6) begin
      do_write(8'(take_bits(8)), rand_len());
      do_read(8'(take_bits(8)), rand_len());
    end

    // Both run past address 255
    do_write(8'hfa, 16'd10);
    do_read(8'hf8, 16'd12);

    unk = 8'(take_bits(8));
    if (unk == dbg_cfg_pkg::CMD_ACK || unk == dbg_cfg_pkg::CMD_READ ||
        unk == dbg_cfg_pkg::CMD_WRITE) begin
      unk = unk ^ 8'h80;
    end
    cmd_q.push_back(unk);
    run_cmd();
    expect_quiet(30, "uart_tx_o start after unknown command");
    cmd_q.push_back(dbg_cfg_pkg::CMD_ACK);
    exp_q.push_back(dbg_cfg_pkg::CMD_ACK);
    run_cmd();
    expect_quiet(20, "uart_tx_o start after second challenge");

    // Three times the FIFO depth, credits run out mid read
    do_read(8'(take_bits(8)), 16'(3 * TxDepth));

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/dbg_cfg_pkg.sv
rtl/dbg_types_pkg.sv
rtl/uart_rx_deser.sv
rtl/dbg_cmd_engine.sv
rtl/uart_tx_ser.sv
rtl/uart_dbg_bridge.sv
tb/tb_uart_dbg_bridge.sv

/* Makefile */
# Verilator build and run for the UART debug bridge

VERILATOR ?= verilator
TOP       ?= tb_uart_dbg_bridge
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
	  echo "simulation did not complete, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
